//--- verilog.f
+incdir+testbench
logic/fdc_pkg.sv
logic/fdc_cru_ctrl.sv
logic/fdc_dsr_rom.sv
logic/fdc_wd_core.sv
logic/fdc_mock_drive.sv
logic/fdc_service_regs.sv
logic/peb_fdc.sv
testbench/tb_peb_fdc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module tb_peb_fdc --Mdir "$BUILD_DIR" -o sim_peb_fdc
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/sim_peb_fdc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
exit 0

//--- testbench/tb_peb_fdc_tests.svh
`ifndef TB_PEB_FDC_TESTS_SVH
`define TB_PEB_FDC_TESTS_SVH

   localparam logic [15:0] CORE_RD = 16'h5FF0;   // plus twice the register number
   localparam logic [15:0] CORE_WR = 16'h5FF8;
   localparam logic [13:0] SVC_REG = 14'h2000;   // register space with the index in the low bits

   function automatic logic [12:0] rom_addr(input int i);
      return 13'(i * 'h1F3 + 1);                 // stays below the controller page
   endfunction

   task automatic motor_start();
      cru_write(1, 1'b0);
      cru_write(1, 1'b1);
   endtask

   task automatic core_write(input int regno, input logic [7:0] value);
      cpu_write(CORE_WR | 16'(regno << 1), ~value);   // bus is inverted
   endtask

   task automatic core_read(input int regno, output logic [7:0] value);
      logic [7:0] raw;
      int waits;
      cpu_read(CORE_RD | 16'(regno << 1), raw, waits);
      value = ~raw;
   endtask

   task automatic wait_not_busy();
      logic [7:0] stat;
      int n;
      n = 0;
      core_read(0, stat);
      while (stat[0] && n < BUS_LIMIT) begin
         core_read(0, stat);
         n++;
      end
      if (stat[0])
         note_failure("controller never cleared busy");
   endtask

   task automatic select_drive_one(input logic [7:0] image_bits);
      cru_write(0, 1'b1);
      wb_write(SVC_REG, image_bits);
      cru_write(4, 1'b1);
      motor_start();
   endtask

   task automatic test_cru_bits();
      logic [7:0] reset_vals;
      logic v;
      reset_vals = 8'b0101_0000;                 // not-motor and the constant 1
      @(negedge clk);
      check_equal("ready_o", ready, 1'b1);
      check_equal("wb_ack_o", wb_ack, 1'b0);
      check_equal("led_o", led, 1'b0);
      check_equal("drive_activity_o", drive_activity, 3'b000);
      for (int i = 0; i < 8; i++) begin
         cru_read(i, v);
         check_equal($sformatf("cruin_o[%0d]", i), v, reset_vals[i]);
      end
      check_equal("cru_select_o", cru_select, 1'b1);
      cru_write(0, 1'b1);
      @(negedge clk);
      check_equal("led_o", led, 1'b1);
      cru_write(2, 1'b1);
      cru_write(3, 1'b1);
      @(negedge clk);
      check_equal("ready_o", ready, 1'b1);       // no wait outside the window
      motor_start();
      cru_read(4, v);
      check_equal("cruin_o[4]", v, 1'b0);
      for (int i = 1; i <= 3; i++) begin
         cru_write(3 + i, 1'b1);
         cru_read(i, v);
         check_equal($sformatf("cruin_o[%0d]", i), v, 1'b1);
         check_equal("drive_activity_o", drive_activity, 3'b100 >> (i - 1));
         cru_write(3 + i, 1'b0);
         cru_read(i, v);
         check_equal($sformatf("cruin_o[%0d]", i), v, 1'b0);
      end
      cru_write(7, 1'b1);
      cru_read(7, v);
      check_equal("cruin_o[7]", v, 1'b1);
      cru_write(7, 1'b0);
      @(posedge clk);
      enable <= 1'b0;
      cru_write(0, 1'b1);
      @(negedge clk);
      check_equal("cru_select_o", cru_select, 1'b0);
      check_equal("led_o", led, 1'b0);
      @(posedge clk);
      enable <= 1'b1;
      @(negedge clk);
      check_equal("led_o", led, 1'b0);
   endtask

   task automatic test_dsr_rom();
      logic [7:0] rom_bytes [16];
      logic [7:0] got;
      int waits;
      cru_write(0, 1'b1);
      @(negedge clk);
      check_equal("q_select_o", q_select, 1'b0);   // cru space
      for (int i = 0; i < 16; i++) begin
         rom_bytes[i] = 8'($random(seed));
         wb_write(14'(rom_addr(i)), rom_bytes[i]);
      end
      for (int i = 0; i < 16; i++) begin
         wb_read(14'(rom_addr(i)), got);
         check_equal($sformatf("wb_dat_o rom[%0h]", rom_addr(i)), got, rom_bytes[i]);
      end
      for (int i = 0; i < 16; i++) begin
         cpu_read(16'h4000 | 16'(rom_addr(i)), got, waits);
         check_equal($sformatf("q_o rom[%0h]", rom_addr(i)), got, rom_bytes[i]);
      end
      @(negedge clk);
      check_equal("q_select_o", q_select, 1'b1);
   endtask

   task automatic test_motor_timeout();
      time t0;
      int cycles;
      int n;
      logic v;
      cru_write(4, 1'b1);
      motor_start();
      t0 = $time;
      cru_read(4, v);
      check_equal("cruin_o[4]", v, 1'b0);
      check_equal("drive_activity_o[1]", drive_activity[1], 1'b1);
      n = 0;
      while (drive_activity[1] && n < 8 * MOTOR_TICKS) begin
         @(negedge clk);
         n++;
      end
      cycles = int'(($time - t0) / CLK_PERIOD);
      check_count++;
      if (cycles < 4 * MOTOR_TICKS - 4 || cycles > 4 * MOTOR_TICKS + 4) begin
         error_count++;
         $display("[ERROR] %0t ns drive_activity_o[1] fell after %0d cycles, expected %0d",
                  $time, cycles, 4 * MOTOR_TICKS);
      end
      check_equal("cruin_o[4]", cruin, 1'b1);
   endtask

   task automatic test_seek();
      logic [7:0] target;
      logic [7:0] got;
      target = 8'd5;
      select_drive_one(8'h70);
      core_write(3, target);
      core_write(0, 8'h10);                      // seek
      wait_not_busy();
      core_read(1, got);
      check_equal("track register", got, target);
      wb_read(SVC_REG | 14'd4, got);
      check_equal("service reg 4", got, {1'b0, target[5:0], 1'b0});
      wb_read(SVC_REG | 14'd6, got);
      check_equal("service reg 6", got, 8'h10);
   endtask

   task automatic test_restore_status();
      logic [7:0] got;
      select_drive_one(8'h70);
      core_write(0, 8'h00);                      // restore
      wait_not_busy();
      core_read(1, got);
      check_equal("track register", got, 8'd0);
      core_read(0, got);
      check_equal("status bit 2", got[2], 1'b1);
      check_equal("status bit 7", got[7], 1'b0);
      wb_write(SVC_REG, 8'h74);                  // drive 1 write-protected
      wb_read(SVC_REG, got);
      check_equal("service reg 0", got, 8'h74);
      core_read(0, got);
      check_equal("status bit 6", got[6], 1'b1);
      wb_write(SVC_REG, 8'h30);                  // drive 1 unmounted
      core_read(0, got);
      check_equal("status bit 7", got[7], 1'b1);
      wb_write(SVC_REG, 8'h70);
   endtask

   task automatic test_wait_states();
      logic [7:0] raw;
      logic [7:0] got;
      int waits;
      select_drive_one(8'h70);
      core_write(3, 8'd8);
      core_write(0, 8'h10);
      cru_write(2, 1'b1);                        // waiten
      cpu_read(CORE_RD, raw, waits);
      if (waits == 0)
         note_failure("ready_o was not held low while the seek ran");
      got = ~raw;
      check_equal("status bit 0", got[0], 1'b0);
      @(negedge clk);
      check_equal("ready_o", ready, 1'b1);
      cru_write(2, 1'b0);
      core_read(1, got);
      check_equal("track register", got, 8'd8);
   endtask

`endif

//--- testbench/tb_peb_fdc.sv
`timescale 1ns/1ns

module tb_peb_fdc import fdc_pkg::*; ();

   localparam int MOTOR_TICKS = 200;
   localparam int STEP_TICKS  = 3;
   localparam int REV_TICKS   = 50;
   localparam int NUM_DRIVES  = 3;
   localparam int CLK_PERIOD  = 20;
   localparam int BUS_LIMIT   = 2000;
   // rough length of all tests in clocks, four strobes make one step tick
   localparam int TEST_CYCLES = 600 + 16 * 24 + 4 * MOTOR_TICKS
                                + 3 * 40 * (4 * STEP_TICKS + 8);

   logic       clk;
   logic       reset;
   logic       clk_3mhz_en;
   logic [1:0] en_div;
   logic       enable;
   cpu_addr_t  a;
   cpu_data_t  d;
   logic       memen, we, cruclk;
   cpu_data_t  q;
   logic       q_select, cruin, cru_select, ready, led;
   logic [1:3] drive_activity;
   wb_addr_t   wb_adr;
   cpu_data_t  wb_dat_w, wb_dat_r;
   logic       wb_we, wb_stb, wb_cyc, wb_ack;
   logic [0:0] wb_sel;
   int         check_count, error_count, seed;

   peb_fdc #(
      .MOTOR_TICKS(MOTOR_TICKS), .STEP_TICKS(STEP_TICKS),
      .REV_TICKS(REV_TICKS), .NUM_DRIVES(NUM_DRIVES)
   ) u_dut (
      .clk(clk), .reset(reset), .clk_3mhz_en_i(clk_3mhz_en), .enable_i(enable),
      .a_i(a), .d_i(d), .memen_i(memen), .we_i(we), .cruclk_i(cruclk),
      .q_o(q), .q_select_o(q_select), .cruin_o(cruin), .cru_select_o(cru_select),
      .ready_o(ready), .led_o(led), .drive_activity_o(drive_activity),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_we_i(wb_we),
      .wb_sel_i(wb_sel), .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_ack_o(wb_ack));

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      en_div      <= en_div + 2'd1;
      clk_3mhz_en <= (en_div == 2'd3);    // one clock in four
   end

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic note_failure(input string what);
      error_count++;
      $display("%0t ns: %s", $time, what);
   endtask

   task automatic cru_write(input int bit_no, input logic value);
      @(posedge clk);
      a      <= 16'h1100 | 16'(bit_no << 1) | 16'(value);
      cruclk <= 1'b1;
      @(posedge clk);
      cruclk <= 1'b0;
   endtask

   task automatic cru_read(input int bit_no, output logic value);
      @(posedge clk);
      a <= 16'h1100 | 16'(bit_no << 1);
      @(negedge clk);
      value = cruin;
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] value);
      @(posedge clk);
      a     <= addr;
      d     <= value;
      memen <= 1'b1;
      we    <= 1'b1;
      @(posedge clk);
      memen <= 1'b0;
      we    <= 1'b0;
   endtask

   task automatic cpu_read(input logic [15:0] addr, output logic [7:0] value,
                           output int waits);
      @(posedge clk);
      a     <= addr;
      memen <= 1'b1;
      we    <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      waits = 0;
      while (!ready && waits < BUS_LIMIT) begin
         @(negedge clk);
         waits++;
      end
      if (!ready)
         note_failure("ready_o stayed low during a CPU read");
      value = q;
      @(posedge clk);
      memen <= 1'b0;
   endtask

   task automatic wb_write(input logic [13:0] addr, input logic [7:0] value);
      int n;
      @(posedge clk);
      wb_adr   <= addr;
      wb_dat_w <= value;
      wb_we    <= 1'b1;
      wb_stb   <= 1'b1;
      wb_cyc   <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!wb_ack && n < BUS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!wb_ack)
         note_failure("Wishbone write was never acknowledged");
      @(posedge clk);
      wb_we  <= 1'b0;
      wb_stb <= 1'b0;
      wb_cyc <= 1'b0;
   endtask

   task automatic wb_read(input logic [13:0] addr, output logic [7:0] value);
      int n;
      @(posedge clk);
      wb_adr <= addr;
      wb_we  <= 1'b0;
      wb_stb <= 1'b1;
      wb_cyc <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!wb_ack && n < BUS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!wb_ack)
         note_failure("Wishbone read was never acknowledged");
      value = wb_dat_r;
      @(posedge clk);
      wb_stb <= 1'b0;
      wb_cyc <= 1'b0;
   endtask

`include "tb_peb_fdc_tests.svh"

   initial begin
      #(4 * TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      seed        = 15804;
      check_count = 0;
      error_count = 0;
      en_div      = 2'd0;
      clk_3mhz_en = 1'b0;
      reset       = 1'b1;
      enable      = 1'b1;
      a           = '0;
      d           = '0;
      memen       = 1'b0;
      we          = 1'b0;
      cruclk      = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      wb_we       = 1'b0;
      wb_sel      = 1'b1;
      wb_stb      = 1'b0;
      wb_cyc      = 1'b0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      test_cru_bits();
      test_dsr_rom();
      test_motor_timeout();
      test_seek();
      test_restore_status();
      test_wait_states();
      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- logic/peb_fdc.sv
`timescale 1ns/1ns

module peb_fdc import fdc_pkg::*; #(
   parameter int unsigned MOTOR_TICKS = 7896000,
   parameter int unsigned STEP_TICKS  = 18000,
   parameter int unsigned REV_TICKS   = 600000,
   parameter int unsigned NUM_DRIVES  = 3
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       clk_3mhz_en_i,
   input  logic       enable_i,
   input  cpu_addr_t  a_i,
   input  cpu_data_t  d_i,
   input  logic       memen_i,
   input  logic       we_i,
   input  logic       cruclk_i,
   output cpu_data_t  q_o,
   output logic       q_select_o,
   output logic       cruin_o,
   output logic       cru_select_o,
   output logic       ready_o,
   output logic       led_o,
   output logic [1:3] drive_activity_o,
   input  wb_addr_t   wb_adr_i,
   input  cpu_data_t  wb_dat_i,
   output cpu_data_t  wb_dat_o,
   input  logic       wb_we_i,
   input  logic [0:0] wb_sel_i,
   input  logic       wb_stb_i,
   input  logic       wb_cyc_i,
   output logic       wb_ack_o
);

   cru_bits_s   cru;
   logic        motor_on;
   logic        fdc_page;
   logic        fdc_win;
   logic        dsr_sel;
   logic        core_rd;
   logic        core_wr;
   logic [7:0]  core_dal;
   logic [7:0]  core_cmd;
   logic        intrq;
   logic        hld;
   step_cmd_s   step_cmd;
   cpu_data_t   rom_data;
   cpu_data_t   reg_q;
   logic        rom_wb_rd;
   logic        rom_wb_wr;
   logic [2:0]  mounted;
   logic [2:0]  wprot;
   drive_stat_s chain_stat  [0:NUM_DRIVES];
   track_t      chain_track [0:NUM_DRIVES];

   assign fdc_page     = (a_i[0:11] == 12'h5FF);
   assign fdc_win      = cru.pgena && memen_i && fdc_page;
   assign q_select_o   = cru.pgena && (a_i[0:2] == 3'b010);
   assign cru_select_o = enable_i && (a_i[0:7] == 8'h11);
   assign dsr_sel      = q_select_o && memen_i && !we_i;
   assign core_rd      = fdc_win && !a_i[15] && !a_i[12] && !we_i;
   assign core_wr      = fdc_win && !a_i[15] && a_i[12] && we_i;
   assign q_o          = fdc_win ? ~core_dal : rom_data;   // controller bus is inverted
   assign led_o        = cru.pgena;

   assign rom_wb_rd = wb_cyc_i && wb_stb_i && !wb_we_i && !wb_adr_i[0];
   assign rom_wb_wr = wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_o && wb_sel_i[0] && !wb_adr_i[0];
   assign wb_dat_o  = wb_adr_i[0] ? reg_q : rom_data;

   fdc_cru_ctrl #(.MOTOR_TICKS(MOTOR_TICKS)) u_cru (
      .clk(clk), .reset(reset), .enable_i(enable_i), .clk_3mhz_en_i(clk_3mhz_en_i),
      .a_i(a_i), .cru_wr_i(cruclk_i && cru_select_o), .fdc_win_i(fdc_win),
      .hld_i(hld), .intrq_i(intrq), .cru_o(cru), .drive_act_o(drive_activity_o),
      .motor_on_o(motor_on), .cruin_o(cruin_o), .ready_o(ready_o));

   fdc_dsr_rom u_rom (
      .clk(clk), .cpu_rd_i(dsr_sel), .cpu_addr_i(a_i[3:15]), .wb_rd_i(rom_wb_rd),
      .wb_wr_i(rom_wb_wr), .wb_addr_i(wb_adr_i[1:13]), .wb_dat_i(wb_dat_i),
      .data_o(rom_data));

   fdc_wd_core #(.STEP_TICKS(STEP_TICKS)) u_core (
      .clk(clk), .reset(reset), .clk_3mhz_en_i(clk_3mhz_en_i), .cs_i(fdc_win),
      .rd_i(core_rd), .wr_i(core_wr), .reg_i(a_i[13:14]), .dal_i(~d_i),
      .dal_o(core_dal), .hlt_i(cru.hlt), .stat_i(chain_stat[0]), .step_o(step_cmd),
      .hld_o(hld), .intrq_o(intrq), .cmd_o(core_cmd));

   fdc_service_regs u_svc (
      .clk(clk), .reset(reset), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_we_i(wb_we_i), .wb_sel_i(wb_sel_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .wb_ack_o(wb_ack_o), .rom_busy_i(dsr_sel), .track_i(chain_track[0]),
      .side_i(cru.side), .cmd_i(core_cmd), .reg_q_o(reg_q), .mounted_o(mounted),
      .wprot_o(wprot));

   // end of chain answers nothing
   assign chain_stat[NUM_DRIVES]  = '0;
   assign chain_track[NUM_DRIVES] = '0;

   for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_drive
      fdc_mock_drive #(.REV_TICKS(REV_TICKS)) u_drive (
         .clk(clk), .clk_3mhz_en_i(clk_3mhz_en_i), .sel_i(drive_activity_o[i+1]),
         .mounted_i(mounted[i]), .wprot_i(wprot[i]), .motor_i(motor_on),
         .step_i(step_cmd), .next_i(chain_stat[i+1]), .next_track_i(chain_track[i+1]),
         .stat_o(chain_stat[i]), .track_o(chain_track[i]));
   end

endmodule

//--- logic/fdc_service_regs.sv
`timescale 1ns/1ns

module fdc_service_regs import fdc_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  wb_addr_t   wb_adr_i,
   input  cpu_data_t  wb_dat_i,
   input  logic       wb_we_i,
   input  logic [0:0] wb_sel_i,
   input  logic       wb_stb_i,
   input  logic       wb_cyc_i,
   output logic       wb_ack_o,
   input  logic       rom_busy_i,
   input  track_t     track_i,
   input  logic       side_i,
   input  logic [7:0] cmd_i,
   output cpu_data_t  reg_q_o,
   output logic [2:0] mounted_o,
   output logic [2:0] wprot_o
);

   logic reg_wr;

   assign reg_wr = wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_o && wb_sel_i[0] && wb_adr_i[0];

   always_ff @(posedge clk) begin
      if (reset || !wb_cyc_i || !wb_stb_i || wb_ack_o)
         wb_ack_o <= 1'b0;
      else if (!wb_adr_i[0])
         wb_ack_o <= wb_we_i || !rom_busy_i;   // rom read waits for the cpu
      else
         wb_ack_o <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mounted_o <= '0;
         wprot_o   <= '0;
      end else if (reg_wr && wb_adr_i[10:13] == 4'd0) begin
         mounted_o <= {wb_dat_i[3], wb_dat_i[2], wb_dat_i[1]};   // bit 1 is drive 1
         wprot_o   <= {wb_dat_i[7], wb_dat_i[6], wb_dat_i[5]};
      end
   end

   always_comb begin
      reg_q_o = '0;
      case (wb_adr_i[10:13])
         4'd0: begin
            reg_q_o[1:3] = {mounted_o[0], mounted_o[1], mounted_o[2]};
            reg_q_o[5:7] = {wprot_o[0], wprot_o[1], wprot_o[2]};
         end
         4'd4: reg_q_o[1:7] = {track_i[5:0], side_i};
         4'd6: reg_q_o = cmd_i;
         default: ;
      endcase
   end

endmodule

//--- logic/fdc_mock_drive.sv
`timescale 1ns/1ns

module fdc_mock_drive import fdc_pkg::*; #(
   parameter int unsigned REV_TICKS = 600000
) (
   input  logic        clk,
   input  logic        clk_3mhz_en_i,
   input  logic        sel_i,
   input  logic        mounted_i,
   input  logic        wprot_i,
   input  logic        motor_i,
   input  step_cmd_s   step_i,
   input  drive_stat_s next_i,
   input  track_t      next_track_i,
   output drive_stat_s stat_o,
   output track_t      track_o
);

   localparam int RW = $clog2(REV_TICKS + 1);
   localparam logic [RW-1:0] REV_LAST = RW'(REV_TICKS - 1);

   logic [5:0]    head_q  = 6'd0;
   logic [RW-1:0] rev_cnt = '0;
   logic          index_q = 1'b0;
   logic          spinning;

   assign spinning = mounted_i && motor_i;

   always_ff @(posedge clk) begin
      if (sel_i && step_i.step) begin
         if (step_i.dir && head_q != 6'd39)
            head_q <= head_q + 6'd1;
         else if (!step_i.dir && head_q != 6'd0)
            head_q <= head_q - 6'd1;
      end
   end

   // one index strobe per revolution
   always_ff @(posedge clk) begin
      if (clk_3mhz_en_i) begin
         index_q <= spinning && (rev_cnt == REV_LAST);
         if (spinning)
            rev_cnt <= (rev_cnt == REV_LAST) ? '0 : rev_cnt + 1'b1;
      end
   end

   always_comb begin
      if (sel_i) begin
         stat_o.track0 = (head_q == 6'd0);
         stat_o.index  = index_q;
         stat_o.ready  = spinning;
         stat_o.wprot  = wprot_i;
         track_o       = {2'b00, head_q};
      end else begin
         stat_o  = next_i;          // pass the next drive along
         track_o = next_track_i;
      end
   end

endmodule

//--- logic/fdc_wd_core.sv
`timescale 1ns/1ns

module fdc_wd_core import fdc_pkg::*; #(
   parameter int unsigned STEP_TICKS = 18000
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        clk_3mhz_en_i,
   input  logic        cs_i,
   input  logic        rd_i,
   input  logic        wr_i,
   input  logic [1:0]  reg_i,
   input  logic [7:0]  dal_i,
   output logic [7:0]  dal_o,
   input  logic        hlt_i,
   input  drive_stat_s stat_i,
   output step_cmd_s   step_o,
   output logic        hld_o,
   output logic        intrq_o,
   output logic [7:0]  cmd_o
);

   localparam int TW = $clog2(STEP_TICKS + 1);
   localparam logic [TW-1:0] STEP_LOAD = TW'(STEP_TICKS);

   wd_state_e     state_q;
   wd_state_e     fin_state;
   track_t        track_q;
   logic [7:0]    sector_q;
   logic [7:0]    data_q;
   logic [7:0]    cmd_q;
   logic          busy;
   logic          seek_err;
   logic          dir_q;
   logic          step_q;
   logic          stepped;
   logic [7:0]    step_cnt;
   logic [TW-1:0] tick_cnt;
   logic [7:0]    status;
   logic          cmd_wr;
   logic          force_int;
   logic          step_dir;

   assign cmd_wr    = cs_i && wr_i && (reg_i == 2'd0);
   assign force_int = cmd_wr && (dal_i[7:4] == 4'hD);
   assign fin_state = cmd_q[2] ? WD_VERIFY : WD_DONE;   // verify flag

   always_comb begin
      case (cmd_q[6:5])
         2'b10:   step_dir = 1'b1;                      // step-in
         2'b11:   step_dir = 1'b0;                      // step-out
         default: step_dir = dir_q;                     // step keeps the last direction
      endcase
   end

   always_ff @(posedge clk) begin
      if (cs_i && wr_i && reg_i == 2'd2)
         sector_q <= dal_i;
      if (cs_i && wr_i && reg_i == 2'd3)
         data_q <= dal_i;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q  <= WD_IDLE;
         busy     <= 1'b0;
         intrq_o  <= 1'b0;
         hld_o    <= 1'b0;
         seek_err <= 1'b0;
         dir_q    <= 1'b0;
         step_q   <= 1'b0;
         stepped  <= 1'b0;
         step_cnt <= '0;
         tick_cnt <= '0;
         track_q  <= '0;
         cmd_q    <= '0;
      end else begin
         step_q <= 1'b0;
         if (cs_i && wr_i && reg_i == 2'd1)
            track_q <= dal_i;
         if (force_int) begin
            cmd_q   <= dal_i;
            busy    <= 1'b0;
            intrq_o <= 1'b1;
            state_q <= WD_IDLE;
         end else begin
            case (state_q)
               WD_IDLE: begin
                  if (cmd_wr) begin
                     cmd_q <= dal_i;
                     if (!dal_i[7]) begin              // type I only, others ignored
                        busy     <= 1'b1;
                        intrq_o  <= 1'b0;
                        seek_err <= 1'b0;
                        hld_o    <= dal_i[3];
                        stepped  <= 1'b0;
                        step_cnt <= '0;
                        state_q  <= WD_SETTLE;
                     end
                  end
               end
               WD_SETTLE: begin
                  if (cmd_q[6:5] != 2'b00) begin       // step, step-in, step-out
                     if (stepped) begin
                        state_q <= fin_state;
                     end else begin
                        stepped  <= 1'b1;
                        dir_q    <= step_dir;
                        step_q   <= 1'b1;
                        tick_cnt <= STEP_LOAD;
                        state_q  <= WD_STEP_WAIT;
                        if (cmd_q[4])
                           track_q <= step_dir ? track_q + 8'd1 : track_q - 8'd1;
                     end
                  end else if (!cmd_q[4]) begin        // restore
                     if (stat_i.track0) begin
                        track_q <= '0;
                        state_q <= fin_state;
                     end else if (step_cnt == 8'hFF) begin
                        seek_err <= 1'b1;               // track 0 never seen
                        state_q  <= WD_DONE;
                     end else begin
                        step_cnt <= step_cnt + 8'd1;
                        dir_q    <= 1'b0;
                        step_q   <= 1'b1;
                        tick_cnt <= STEP_LOAD;
                        state_q  <= WD_STEP_WAIT;
                     end
                  end else begin                       // seek
                     if (track_q == data_q) begin
                        state_q <= fin_state;
                     end else begin
                        dir_q    <= data_q > track_q;
                        track_q  <= (data_q > track_q) ? track_q + 8'd1 : track_q - 8'd1;
                        step_q   <= 1'b1;
                        tick_cnt <= STEP_LOAD;
                        state_q  <= WD_STEP_WAIT;
                     end
                  end
               end
               WD_STEP_WAIT: begin
                  if (clk_3mhz_en_i) begin
                     tick_cnt <= tick_cnt - 1'b1;
                     if (tick_cnt <= 1)
                        state_q <= WD_SETTLE;
                  end
               end
               WD_VERIFY: begin
                  if (clk_3mhz_en_i)
                     state_q <= WD_DONE;
               end
               WD_DONE: begin
                  busy    <= 1'b0;
                  intrq_o <= 1'b1;
                  state_q <= WD_IDLE;
               end
               default: state_q <= WD_IDLE;
            endcase
         end
      end
   end

   assign status = {!stat_i.ready, stat_i.wprot, hld_o && hlt_i, seek_err,
                    1'b0, stat_i.track0, stat_i.index, busy};

   always_comb begin
      dal_o = 8'h00;
      if (cs_i && rd_i) begin
         case (reg_i)
            2'd0: dal_o = status;
            2'd1: dal_o = track_q;
            2'd2: dal_o = sector_q;
            2'd3: dal_o = data_q;
         endcase
      end
   end

   assign step_o.step = step_q;
   assign step_o.dir  = dir_q;
   assign cmd_o       = cmd_q;

   a_step_while_busy: assert property (@(posedge clk) disable iff (reset)
      step_q |-> busy);

endmodule

//--- logic/fdc_dsr_rom.sv
`timescale 1ns/1ns

module fdc_dsr_rom import fdc_pkg::*; (
   input  logic      clk,
   input  logic      cpu_rd_i,
   input  rom_addr_t cpu_addr_i,
   input  logic      wb_rd_i,
   input  logic      wb_wr_i,
   input  rom_addr_t wb_addr_i,
   input  cpu_data_t wb_dat_i,
   output cpu_data_t data_o
);

   cpu_data_t rom_mem [0:8191];
   rom_addr_t rd_addr;

   assign rd_addr = cpu_rd_i ? cpu_addr_i : wb_addr_i;   // cpu has priority

   always_ff @(posedge clk) begin
      if (cpu_rd_i || wb_rd_i)
         data_o <= rom_mem[rd_addr];
      if (wb_wr_i)
         rom_mem[wb_addr_i] <= wb_dat_i;
   end

endmodule

//--- logic/fdc_cru_ctrl.sv
`timescale 1ns/1ns

module fdc_cru_ctrl import fdc_pkg::*; #(
   parameter int unsigned MOTOR_TICKS = 7896000
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       enable_i,
   input  logic       clk_3mhz_en_i,
   input  cpu_addr_t  a_i,
   input  logic       cru_wr_i,
   input  logic       fdc_win_i,
   input  logic       hld_i,
   input  logic       intrq_i,
   output cru_bits_s  cru_o,
   output logic [1:3] drive_act_o,
   output logic       motor_on_o,
   output logic       cruin_o,
   output logic       ready_o
);

   localparam logic [23:0] MOTOR_LOAD = 24'(MOTOR_TICKS);

   cru_bits_s   cru_q;
   logic        kaclk_prev;
   logic        dvena;
   logic [23:0] ena_count;
   logic        wait_done;

   always_ff @(posedge clk) begin
      if (reset || !enable_i) begin
         cru_q <= '0;
      end else if (cru_wr_i) begin
         case (a_i[12:14])
            3'd0: cru_q.pgena   <= a_i[15];
            3'd1: cru_q.kaclk   <= a_i[15];
            3'd2: cru_q.waiten  <= a_i[15];
            3'd3: cru_q.hlt     <= a_i[15];
            3'd4: cru_q.dsel[1] <= a_i[15];
            3'd5: cru_q.dsel[2] <= a_i[15];
            3'd6: cru_q.dsel[3] <= a_i[15];
            3'd7: cru_q.side    <= a_i[15];
         endcase
      end
   end

   // motor monoflop retriggered by a rising kaclk
   always_ff @(posedge clk) begin
      if (reset) begin
         dvena      <= 1'b0;
         kaclk_prev <= 1'b0;
      end else begin
         kaclk_prev <= cru_q.kaclk;
         if (cru_q.kaclk && !kaclk_prev) begin
            dvena     <= 1'b1;
            ena_count <= MOTOR_LOAD;
         end else if (dvena && clk_3mhz_en_i) begin
            ena_count <= ena_count - 24'd1;
            if (ena_count <= 24'd1)
               dvena <= 1'b0;          // last tick
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset || !fdc_win_i)
         wait_done <= 1'b0;
      else if (clk_3mhz_en_i && (intrq_i || !dvena))
         wait_done <= 1'b1;
   end

   always_comb begin
      case (a_i[12:14])
         3'd0: cruin_o = hld_i;
         3'd1: cruin_o = drive_act_o[1];
         3'd2: cruin_o = drive_act_o[2];
         3'd3: cruin_o = drive_act_o[3];
         3'd4: cruin_o = !dvena;
         3'd5: cruin_o = 1'b0;
         3'd6: cruin_o = 1'b1;
         3'd7: cruin_o = cru_q.side;
      endcase
   end

   assign cru_o       = cru_q;
   assign motor_on_o  = dvena;
   assign drive_act_o = cru_q.dsel & {3{dvena}};
   assign ready_o     = !fdc_win_i || !cru_q.waiten || wait_done;

   // the cpu is let go one clock after the controller reports
   a_release_on_report: assert property (@(posedge clk) disable iff (reset)
      !ready_o && clk_3mhz_en_i && (intrq_i || !dvena) |=> ready_o);

endmodule

//--- logic/fdc_pkg.sv
package fdc_pkg;

   typedef logic [0:15] cpu_addr_t;   // bit 0 is the msb
   typedef logic [0:7]  cpu_data_t;
   typedef logic [0:12] rom_addr_t;
   typedef logic [0:13] wb_addr_t;    // bit 0 rom/regs, bits 10..13 reg index
   typedef logic [7:0]  track_t;

   typedef struct packed {
      logic       pgena;
      logic       kaclk;
      logic       waiten;
      logic       hlt;
      logic       side;
      logic [1:3] dsel;              // one per drive
   } cru_bits_s;

   typedef struct packed {
      logic track0;
      logic index;
      logic ready;
      logic wprot;
   } drive_stat_s;

   typedef struct packed {
      logic step;
      logic dir;                     // 1 = inward
   } step_cmd_s;

   typedef enum logic [2:0] {
      WD_IDLE,
      WD_SETTLE,
      WD_STEP_WAIT,
      WD_VERIFY,
      WD_DONE
   } wd_state_e;

endpackage
